//--- hdl/conv_geom_pkg.sv
package conv_geom_pkg;

    //////////////////////////////////////////////////
    // layer geometry types
    //////////////////////////////////////////////////

    // channels, filters, widths, sizes, pixel indices
    typedef logic [15:0] dim_t;

    typedef logic [15:0] addr_t;  // word address, either buffer

    typedef logic [7:0]  blk_t;   // block index or block count

endpackage

//--- hdl/conv_timing_pkg.sv
package conv_timing_pkg;

    //////////////////////////////////////////////////
    // PE array pipeline depths, in cycles
    //////////////////////////////////////////////////

    localparam int unsigned LAT_MAC      = 1;  // multiplier
    localparam int unsigned LAT_ADD_TREE = 2;  // lane reduction
    localparam int unsigned LAT_FB_ADD   = 1;  // partial sum add
    localparam int unsigned LAT_NL       = 1;  // non-linearity

endpackage

//--- hdl/conv_geometry.sv
`timescale 1ns/1ns

module conv_geometry
    import conv_geom_pkg::*;
#(
    parameter int N_PE     = 4,
    parameter int LOG_N_PE = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  dim_t            cfg_channels,
    input  dim_t            cfg_filters,
    input  dim_t            cfg_data_wid,
    input  dim_t            cfg_data_hei,
    input  dim_t            cfg_filter_wid,
    input  dim_t            cfg_filter_hei,
    output dim_t            filters,
    output dim_t            data_wid,
    output dim_t            filter_wid,
    output dim_t            filter_hei,
    output dim_t            input_size,
    output dim_t            out_wid,
    output dim_t            output_size,
    output dim_t            filter_size,
    output blk_t            fbe,
    output blk_t            cbe,
    output logic [N_PE-1:0] last_rows,
    output logic [N_PE-1:0] last_lanes
);

    dim_t                channels;
    dim_t                data_hei;
    dim_t                out_hei;
    logic [LOG_N_PE-1:0] f_rem;  // filters in a partial last block
    logic [LOG_N_PE-1:0] c_rem;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            channels   <= '0;
            filters    <= '0;
            data_wid   <= '0;
            data_hei   <= '0;
            filter_wid <= '0;
            filter_hei <= '0;
        end else if (start) begin
            channels   <= cfg_channels;
            filters    <= cfg_filters;
            data_wid   <= cfg_data_wid;
            data_hei   <= cfg_data_hei;
            filter_wid <= cfg_filter_wid;
            filter_hei <= cfg_filter_hei;
        end
    end

    // valid convolution, stride 1, no padding
    assign input_size  = data_wid * data_hei;
    assign out_wid     = data_wid - filter_wid + 16'd1;
    assign out_hei     = data_hei - filter_hei + 16'd1;
    assign output_size = out_wid * out_hei;
    assign filter_size = filter_wid * filter_hei;

    assign f_rem = filters[LOG_N_PE-1:0];
    assign c_rem = channels[LOG_N_PE-1:0];
    assign fbe   = blk_t'(filters >> LOG_N_PE) + blk_t'(f_rem != '0);  // full blocks + partial
    assign cbe   = blk_t'(channels >> LOG_N_PE) + blk_t'(c_rem != '0);

    always_comb begin
        for (int i = 0; i < N_PE; i++) begin
            last_rows[i]  = (f_rem == '0) || (i < int'(f_rem));  // all ones if full
            last_lanes[i] = (c_rem == '0) || (i < int'(c_rem));
        end
    end

endmodule

//--- hdl/block_sequencer.sv
`timescale 1ns/1ns

module block_sequencer
    import conv_geom_pkg::*;
#(
    parameter int N_PE     = 4,
    parameter int LOG_N_PE = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  dim_t            filters,
    input  dim_t            input_size,
    input  dim_t            filter_size,
    input  blk_t            fbe,
    input  blk_t            cbe,
    input  logic [N_PE-1:0] last_rows,
    input  logic [N_PE-1:0] last_lanes,
    input  logic [N_PE-1:0] ff_rd_en,
    input  addr_t           ff_rd_addr,
    input  logic            pass_done,
    output logic [N_PE-1:0] buf1_rd_en,
    output addr_t           buf1_rd_addr,
    output logic [N_PE-1:0] shift_filter_row,
    output logic [N_PE-1:0] shift_filter_lanes,
    output logic            line_buffer_reset,
    output logic            pass_start,
    output blk_t            fb,
    output blk_t            cb,
    output logic [N_PE-1:0] row_mask,
    output logic [N_PE-1:0] lane_mask,
    output logic            first_cb,
    output logic            last_cb,
    output logic            busy,
    output logic            done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_NEXT_FB,
        S_NEXT_CB,
        S_PUSH,
        S_STREAM
    } state_t;

    state_t              state;
    logic [LOG_N_PE-1:0] f_idx;     // filter row being pushed
    dim_t                k_idx;     // tap within that filter
    logic                sf_valid;  // tap read last cycle
    logic [LOG_N_PE-1:0] sf_row;
    logic                last_tap;
    logic                last_row;
    logic                last_fb;
    addr_t               l1;
    addr_t               tap_addr;

    //////////////////////////////////////////////////
    // block masks and flags
    //////////////////////////////////////////////////

    assign last_fb   = (fb == fbe - 8'd1);
    assign last_cb   = (cb == cbe - 8'd1);
    assign first_cb  = (cb == '0);
    assign row_mask  = last_fb ? last_rows : '1;
    assign lane_mask = last_cb ? last_lanes : '1;

    assign last_tap = (k_idx == filter_size - 16'd1);
    // active rows are contiguous from row 0
    assign last_row = (f_idx == LOG_N_PE'(N_PE - 1)) || !row_mask[f_idx + 1'b1];

    // taps sit after the input region of every lane
    assign l1       = input_size * addr_t'(cbe);
    assign tap_addr = l1 + filter_size * filters * addr_t'(cb)
                    + filter_size * addr_t'({fb, f_idx}) + k_idx;

    //////////////////////////////////////////////////
    // block loops
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            fb       <= '0;
            cb       <= '0;
            f_idx    <= '0;
            k_idx    <= '0;
            sf_valid <= 1'b0;
            sf_row   <= '0;
        end else begin
            sf_valid <= (state == S_PUSH);
            sf_row   <= f_idx;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        fb    <= '0;
                        cb    <= '0;
                        state <= S_PUSH;  // geometry valid from here on
                    end
                end
                S_PUSH: begin
                    if (last_tap) begin
                        k_idx <= '0;
                        if (last_row) begin
                            f_idx <= '0;
                            state <= S_STREAM;
                        end else begin
                            f_idx <= f_idx + 1'b1;
                        end
                    end else begin
                        k_idx <= k_idx + 16'd1;
                    end
                end
                S_STREAM: begin
                    if (pass_done) begin
                        state <= S_NEXT_CB;
                    end
                end
                S_NEXT_CB: begin
                    if (last_cb) begin
                        cb    <= '0;
                        state <= S_NEXT_FB;
                    end else begin
                        cb    <= cb + 8'd1;
                        state <= S_PUSH;
                    end
                end
                S_NEXT_FB: begin
                    if (last_fb) begin
                        state <= S_IDLE;
                    end else begin
                        fb    <= fb + 8'd1;
                        state <= S_PUSH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign pass_start        = (state == S_PUSH) && last_tap && last_row;
    assign done              = (state == S_NEXT_FB) && last_fb;
    assign busy              = (state != S_IDLE);
    assign line_buffer_reset = (state != S_STREAM);

    // filter shift trails its tap read by one cycle
    assign shift_filter_row   = sf_valid ? ({{(N_PE-1){1'b0}}, 1'b1} << sf_row) : '0;
    assign shift_filter_lanes = sf_valid ? lane_mask : '0;

    // buffer 1 port: tap reads while pushing, inputs while streaming
    always_comb begin
        buf1_rd_en   = '0;
        buf1_rd_addr = '0;
        if (state == S_PUSH) begin
            buf1_rd_en   = lane_mask;
            buf1_rd_addr = tap_addr;
        end else if (state == S_STREAM) begin
            buf1_rd_en   = ff_rd_en;
            buf1_rd_addr = ff_rd_addr;
        end
    end

endmodule

//--- hdl/feedforward_sched.sv
`timescale 1ns/1ns

module feedforward_sched
    import conv_geom_pkg::*;
    import conv_timing_pkg::*;
#(
    parameter int N_PE = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pass_start,
    input  blk_t            cb,
    input  blk_t            fb,
    input  logic [N_PE-1:0] row_mask,
    input  logic [N_PE-1:0] lane_mask,
    input  dim_t            input_size,
    input  dim_t            output_size,
    input  dim_t            out_wid,
    input  dim_t            data_wid,
    input  dim_t            filter_wid,
    input  dim_t            filter_hei,
    output logic [N_PE-1:0] ff_rd_en,
    output addr_t           ff_rd_addr,
    output logic [N_PE-1:0] shift_line_rows,
    output logic [N_PE-1:0] shift_line_lanes,
    output logic [N_PE-1:0] mac_rows,
    output logic [N_PE-1:0] mac_lanes,
    output logic [N_PE-1:0] buf2_wr_en,
    output addr_t           buf2_wr_addr,
    output logic            pass_done
);

    logic active;
    dim_t cyc;       // pass cycle number
    dim_t col;       // write-back column gate
    dim_t wr_idx;    // output pixel
    dim_t w_len;     // line buffer fill depth
    dim_t wb_start;
    logic rd_on;
    logic sh_on;
    logic mac_on;
    logic wb_on;
    logic wr_fire;

    //////////////////////////////////////////////////
    // stage windows
    //////////////////////////////////////////////////

    assign w_len    = (filter_hei - 16'd1) * data_wid + filter_wid;
    assign wb_start = w_len + dim_t'(LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD + LAT_NL);

    assign rd_on   = active && (cyc < input_size);
    assign sh_on   = active && (cyc >= 16'd1) && (cyc <= input_size);
    assign mac_on  = active && (cyc >= w_len) && (cyc < input_size);
    assign wb_on   = active && (cyc >= wb_start);
    // gate closes over the filter_wid-1 wrapped columns
    assign wr_fire = wb_on && (col < out_wid) && (wr_idx < output_size);

    assign pass_done = wr_fire && (wr_idx == output_size - 16'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cyc    <= '0;
            col    <= '0;
            wr_idx <= '0;
        end else if (pass_start) begin
            active <= 1'b1;
            cyc    <= '0;
            col    <= '0;
            wr_idx <= '0;
        end else if (active) begin
            cyc <= cyc + 16'd1;
            if (wb_on) begin
                col <= (col == data_wid - 16'd1) ? '0 : col + 16'd1;  // period data_wid
            end
            if (wr_fire) begin
                wr_idx <= wr_idx + 16'd1;
            end
            if (pass_done) begin
                active <= 1'b0;  // last write seen
            end
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign ff_rd_en   = rd_on ? lane_mask : '0;
    assign ff_rd_addr = input_size * addr_t'(cb) + cyc;

    assign shift_line_rows  = sh_on ? row_mask : '0;
    assign shift_line_lanes = sh_on ? lane_mask : '0;
    assign mac_rows         = mac_on ? row_mask : '0;
    assign mac_lanes        = mac_on ? lane_mask : '0;

    assign buf2_wr_en   = wr_fire ? row_mask : '0;  // one write port per filter row
    assign buf2_wr_addr = output_size * addr_t'(fb) + wr_idx;

endmodule

//--- hdl/feedback_sched.sv
`timescale 1ns/1ns

module feedback_sched
    import conv_geom_pkg::*;
    import conv_timing_pkg::*;
#(
    parameter int N_PE = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pass_start,
    input  blk_t            fb,
    input  logic [N_PE-1:0] row_mask,
    input  logic            first_cb,
    input  logic            last_cb,
    input  dim_t            output_size,
    input  dim_t            out_wid,
    input  dim_t            data_wid,
    input  dim_t            filter_wid,
    input  dim_t            filter_hei,
    output logic [N_PE-1:0] buf2_rd_en,
    output addr_t           buf2_rd_addr,
    output logic [N_PE-1:0] feedback_en,
    output logic [N_PE-1:0] nl_en
);

    localparam int N_ST = 3;  // read, feedback add, non-linearity

    logic            active;
    dim_t            cyc;
    dim_t            w_len;
    dim_t            st_start [N_ST];
    dim_t            col [N_ST];
    dim_t            idx [N_ST];
    logic [N_ST-1:0] on;
    logic [N_ST-1:0] fire;

    assign w_len       = (filter_hei - 16'd1) * data_wid + filter_wid;
    assign st_start[0] = w_len + dim_t'(LAT_MAC + LAT_ADD_TREE - 1);  // sum ready next cycle
    assign st_start[1] = st_start[0] + 16'd1;
    assign st_start[2] = w_len + dim_t'(LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD);

    always_comb begin
        for (int s = 0; s < N_ST; s++) begin
            on[s]   = active && (cyc >= st_start[s]);
            fire[s] = on[s] && (col[s] < out_wid) && (idx[s] < output_size);
        end
    end

    //////////////////////////////////////////////////
    // counter and gated indices
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cyc    <= '0;
            for (int s = 0; s < N_ST; s++) begin
                col[s] <= '0;
                idx[s] <= '0;
            end
        end else if (pass_start) begin
            active <= 1'b1;
            cyc    <= '0;
            for (int s = 0; s < N_ST; s++) begin
                col[s] <= '0;
                idx[s] <= '0;
            end
        end else if (active) begin
            cyc <= cyc + 16'd1;
            for (int s = 0; s < N_ST; s++) begin
                if (on[s]) begin
                    col[s] <= (col[s] == data_wid - 16'd1) ? '0 : col[s] + 16'd1;
                end
                if (fire[s]) begin
                    idx[s] <= idx[s] + 16'd1;
                end
            end
            // non-linearity stage finishes last
            if (fire[N_ST-1] && (idx[N_ST-1] == output_size - 16'd1)) begin
                active <= 1'b0;
            end
        end
    end

    // no partial sums to add back on the first channel block
    assign buf2_rd_en   = (fire[0] && !first_cb) ? row_mask : '0;
    assign buf2_rd_addr = output_size * addr_t'(fb) + idx[0];
    assign feedback_en  = (fire[1] && !first_cb) ? row_mask : '0;
    assign nl_en        = (fire[2] && last_cb) ? row_mask : '0;  // final sums only

endmodule

//--- hdl/conv_ctrl_top.sv
`timescale 1ns/1ns

module conv_ctrl_top
    import conv_geom_pkg::*;
#(
    parameter int N_PE = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  dim_t            cfg_channels,
    input  dim_t            cfg_filters,
    input  dim_t            cfg_data_wid,
    input  dim_t            cfg_data_hei,
    input  dim_t            cfg_filter_wid,
    input  dim_t            cfg_filter_hei,
    output logic [N_PE-1:0] buf1_rd_en,
    output addr_t           buf1_rd_addr,
    output logic [N_PE-1:0] buf2_wr_en,
    output addr_t           buf2_wr_addr,
    output logic [N_PE-1:0] buf2_rd_en,
    output addr_t           buf2_rd_addr,
    output logic [N_PE-1:0] shift_filter_row,
    output logic [N_PE-1:0] shift_filter_lanes,
    output logic [N_PE-1:0] shift_line_rows,
    output logic [N_PE-1:0] shift_line_lanes,
    output logic [N_PE-1:0] mac_rows,
    output logic [N_PE-1:0] mac_lanes,
    output logic [N_PE-1:0] feedback_en,
    output logic [N_PE-1:0] nl_en,
    output logic            line_buffer_reset,
    output logic            busy,
    output logic            done
);

    localparam int LOG_N_PE = $clog2(N_PE);

    // sampled layer geometry
    dim_t            filters, data_wid, filter_wid, filter_hei;
    dim_t            input_size, out_wid, output_size, filter_size;
    blk_t            fbe, cbe;
    logic [N_PE-1:0] last_rows, last_lanes;

    // pass control
    logic            pass_start, pass_done;
    blk_t            fb, cb;
    logic [N_PE-1:0] row_mask, lane_mask;
    logic            first_cb, last_cb;
    logic [N_PE-1:0] ff_rd_en;
    addr_t           ff_rd_addr;

    conv_geometry #(.N_PE(N_PE), .LOG_N_PE(LOG_N_PE)) conv_geometry_i (
        .clk, .rst, .start,
        .cfg_channels, .cfg_filters, .cfg_data_wid, .cfg_data_hei,
        .cfg_filter_wid, .cfg_filter_hei,
        .filters, .data_wid, .filter_wid, .filter_hei,
        .input_size, .out_wid, .output_size, .filter_size,
        .fbe, .cbe, .last_rows, .last_lanes
    );

    block_sequencer #(.N_PE(N_PE), .LOG_N_PE(LOG_N_PE)) block_sequencer_i (
        .clk, .rst, .start,
        .filters, .input_size, .filter_size, .fbe, .cbe, .last_rows, .last_lanes,
        .ff_rd_en, .ff_rd_addr, .pass_done,
        .buf1_rd_en, .buf1_rd_addr, .shift_filter_row, .shift_filter_lanes,
        .line_buffer_reset, .pass_start, .fb, .cb, .row_mask, .lane_mask,
        .first_cb, .last_cb, .busy, .done
    );

    feedforward_sched #(.N_PE(N_PE)) feedforward_sched_i (
        .clk, .rst, .pass_start, .cb, .fb, .row_mask, .lane_mask,
        .input_size, .output_size, .out_wid, .data_wid, .filter_wid, .filter_hei,
        .ff_rd_en, .ff_rd_addr, .shift_line_rows, .shift_line_lanes,
        .mac_rows, .mac_lanes, .buf2_wr_en, .buf2_wr_addr, .pass_done
    );

    feedback_sched #(.N_PE(N_PE)) feedback_sched_i (
        .clk, .rst, .pass_start, .fb, .row_mask, .first_cb, .last_cb,
        .output_size, .out_wid, .data_wid, .filter_wid, .filter_hei,
        .buf2_rd_en, .buf2_rd_addr, .feedback_en, .nl_en
    );

endmodule

//--- test/conv_ctrl_tb.sv
`timescale 1ns/1ns

module conv_ctrl_tb
    import conv_geom_pkg::*;
    import conv_timing_pkg::*;
;

    localparam int N_PE = 4;
    localparam int M_PUSH = 1;  // tap reads and filter shifts
    localparam int M_WR   = 2;  // buffer 2 writes
    localparam int M_FB   = 4;  // feedback reads, feedback and nl enables
    localparam int M_TIME = 8;  // exact cycle positions

    logic            clk;
    logic            rst;
    logic            start;
    dim_t            cfg_channels, cfg_filters, cfg_data_wid;
    dim_t            cfg_data_hei, cfg_filter_wid, cfg_filter_hei;
    logic [N_PE-1:0] buf1_rd_en, buf2_wr_en, buf2_rd_en;
    addr_t           buf1_rd_addr, buf2_wr_addr, buf2_rd_addr;
    logic [N_PE-1:0] shift_filter_row, shift_filter_lanes;
    logic [N_PE-1:0] shift_line_rows, shift_line_lanes;
    logic [N_PE-1:0] mac_rows, mac_lanes, feedback_en, nl_en;
    logic            line_buffer_reset, busy, done;

    int          errors = 0;
    int unsigned mcyc = 0;
    int unsigned limit = 0;
    int          done_cnt = 0;
    integer      seed = 42935;
    int          ch, fi, dw, dh, fw, fh;  // current layer
    int          pch, pfi, pdw, pfw;      // random partial layer

    // {cycle, 8'h0, enable or rows, address or lanes}
    logic [63:0] b1_q[$], sf_q[$], sl_q[$], mc_q[$], wr_q[$], rd_q[$], fe_q[$], nl_q[$];
    int unsigned lb_q[$];  // cycles with the line buffer released

    conv_ctrl_top #(.N_PE(N_PE)) conv_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] pack(input int unsigned c, input logic [N_PE-1:0] en,
                                         input logic [15:0] a);
        return {c, 8'h0, 8'(en), a};
    endfunction

    //////////////////////////////////////////////////
    // monitor, sampled just after the rising edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        mcyc = mcyc + 1;
        if (|buf1_rd_en) b1_q.push_back(pack(mcyc, buf1_rd_en, buf1_rd_addr));
        if ((|shift_filter_row) || (|shift_filter_lanes)) begin
            sf_q.push_back(pack(mcyc, shift_filter_lanes, 16'(shift_filter_row)));
        end
        if ((|shift_line_rows) || (|shift_line_lanes)) begin
            sl_q.push_back(pack(mcyc, shift_line_rows, 16'(shift_line_lanes)));
        end
        if ((|mac_rows) || (|mac_lanes)) begin
            mc_q.push_back(pack(mcyc, mac_rows, 16'(mac_lanes)));
        end
        if (|buf2_wr_en) wr_q.push_back(pack(mcyc, buf2_wr_en, buf2_wr_addr));
        if (|buf2_rd_en) rd_q.push_back(pack(mcyc, buf2_rd_en, buf2_rd_addr));
        if (|feedback_en) fe_q.push_back(pack(mcyc, feedback_en, 16'h0));
        if (|nl_en) nl_q.push_back(pack(mcyc, nl_en, 16'h0));
        if (!line_buffer_reset) lb_q.push_back(mcyc);
        if (done) done_cnt++;
        if (limit != 0 && mcyc > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int ceil_div(input int a, input int b);
        return (a + b - 1) / b;
    endfunction

    // timeout share of one layer
    function automatic int budget(input int c, input int f, input int w, input int h,
                                  input int kw, input int kh);
        return 4 * ceil_div(f, N_PE) * ceil_div(c, N_PE) * (w * h + N_PE * kw * kh + 40);
    endfunction

    function automatic logic [N_PE-1:0] block_mask(input int total, input int idx);
        int n;
        n = total - idx * N_PE;
        if (n > N_PE) n = N_PE;
        return N_PE'((1 << n) - 1);
    endfunction

    //////////////////////////////////////////////////
    // layer run and reference check
    //////////////////////////////////////////////////

    task automatic run_layer(input int c, input int f, input int w, input int h,
                             input int kw, input int kh);
        ch = c;
        fi = f;
        dw = w;
        dh = h;
        fw = kw;
        fh = kh;
        b1_q.delete();
        sf_q.delete();
        sl_q.delete();
        mc_q.delete();
        wr_q.delete();
        rd_q.delete();
        fe_q.delete();
        nl_q.delete();
        lb_q.delete();
        done_cnt = 0;
        @(negedge clk);
        cfg_channels   = dim_t'(c);
        cfg_filters    = dim_t'(f);
        cfg_data_wid   = dim_t'(w);
        cfg_data_hei   = dim_t'(h);
        cfg_filter_wid = dim_t'(kw);
        cfg_filter_hei = dim_t'(kh);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_val("busy", 32'(busy), 32'h1);
        while (done_cnt == 0) @(negedge clk);
        repeat (3) @(negedge clk);
        check_val("done count", done_cnt, 1);
        check_val("busy", 32'(busy), 32'h0);
    endtask

    task automatic verify_layer(input int mode);
        int isz, osz, fsz, ow, w_len, fbe, cbe, l1, t0, tc, g, te;
        int ib, is, isl, imc, iw, ir, ie, il, ilb;
        logic [N_PE-1:0] rmask, lmask;
        isz = dw * dh;
        ow  = dw - fw + 1;
        osz = ow * (dh - fh + 1);
        fsz = fw * fh;
        w_len = (fh - 1) * dw + fw;
        fbe = ceil_div(fi, N_PE);
        cbe = ceil_div(ch, N_PE);
        l1  = isz * cbe;
        ib = 0;
        is = 0;
        isl = 0;
        imc = 0;
        iw = 0;
        ir = 0;
        ie = 0;
        il = 0;
        ilb = 0;
        for (int fb = 0; fb < fbe; fb++) begin
            rmask = block_mask(fi, fb);
            for (int cb = 0; cb < cbe; cb++) begin
                lmask = block_mask(ch, cb);
                // filter push, one row after the other
                for (int f = 0; f < N_PE; f++) begin
                    if (rmask[f]) begin
                        for (int k = 0; k < fsz; k++) begin
                            if (ib >= b1_q.size() || is >= sf_q.size()) begin
                                errors++;
                                $display("filter push ended early in block %0d/%0d", fb, cb);
                                return;
                            end
                            tc = int'(b1_q[ib][63:32]);
                            if (mode & M_PUSH) begin
                                check_val("buf1_rd_en", b1_q[ib][23:16], 32'(lmask));
                                check_val("buf1_rd_addr", b1_q[ib][15:0],
                                          l1 + fsz * fi * cb + fsz * (fb * N_PE + f) + k);
                                check_val("shift_filter cycle", sf_q[is][63:32], tc + 1);
                                check_val("shift_filter_row", sf_q[is][15:0], 1 << f);
                                check_val("shift_filter_lanes", sf_q[is][23:16], 32'(lmask));
                            end
                            ib++;
                            is++;
                        end
                    end
                end
                // streaming pass, cycle 0 is the first input read
                if (ib + isz > b1_q.size()) begin
                    errors++;
                    $display("input reads missing in block %0d/%0d", fb, cb);
                    return;
                end
                t0 = int'(b1_q[ib][63:32]);
                for (int t = 0; t < isz; t++) begin
                    check_val("buf1_rd_en", b1_q[ib][23:16], 32'(lmask));
                    check_val("buf1_rd_addr", b1_q[ib][15:0], isz * cb + t);
                    check_val("input read cycle", b1_q[ib][63:32], t0 + t);
                    ib++;
                end
                // line shift on cycles 1 to isz
                for (int t = 1; t <= isz; t++) begin
                    if (isl < sl_q.size()) begin
                        check_val("shift_line_rows", sl_q[isl][23:16], 32'(rmask));
                        check_val("shift_line_lanes", sl_q[isl][15:0], 32'(lmask));
                        check_val("line shift cycle", sl_q[isl][63:32], t0 + t);
                    end
                    isl++;
                end
                // MAC once the line buffer holds a full window
                for (int t = w_len; t < isz; t++) begin
                    if (imc < mc_q.size()) begin
                        check_val("mac_rows", mc_q[imc][23:16], 32'(rmask));
                        check_val("mac_lanes", mc_q[imc][15:0], 32'(lmask));
                        check_val("mac cycle", mc_q[imc][63:32], t0 + t);
                    end
                    imc++;
                end
                for (int j = 0; j < osz; j++) begin
                    g = (j / ow) * dw + (j % ow);  // column gate position
                    if ((mode & M_WR) && iw < wr_q.size()) begin
                        check_val("buf2_wr_en", wr_q[iw][23:16], 32'(rmask));
                        check_val("buf2_wr_addr", wr_q[iw][15:0], osz * fb + j);
                        if (mode & M_TIME) begin
                            check_val("buf2 write cycle", wr_q[iw][63:32],
                                      t0 + w_len + LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD + LAT_NL + g);
                        end
                    end
                    iw++;
                    if (cb > 0) begin
                        if ((mode & M_FB) && ir < rd_q.size() && ie < fe_q.size()) begin
                            check_val("buf2_rd_addr", rd_q[ir][15:0], osz * fb + j);
                            check_val("buf2_rd_en", rd_q[ir][23:16], 32'(rmask));
                            check_val("buf2 read cycle", rd_q[ir][63:32],
                                      t0 + w_len + LAT_MAC + LAT_ADD_TREE - 1 + g);
                            check_val("feedback_en", fe_q[ie][23:16], 32'(rmask));
                            check_val("feedback cycle", fe_q[ie][63:32],
                                      t0 + w_len + LAT_MAC + LAT_ADD_TREE + g);
                        end
                        ir++;
                        ie++;
                    end
                    if (cb == cbe - 1) begin
                        if ((mode & M_FB) && il < nl_q.size()) begin
                            check_val("nl_en", nl_q[il][23:16], 32'(rmask));
                            check_val("nl cycle", nl_q[il][63:32],
                                      t0 + w_len + LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD + g);
                        end
                        il++;
                    end
                end
                // line buffer released from cycle 0 up to the last write
                g  = ((osz - 1) / ow) * dw + (osz - 1) % ow;
                te = w_len + LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD + LAT_NL + g;
                for (int t = 0; t <= te; t++) begin
                    if (ilb < lb_q.size()) begin
                        check_val("line_buffer_reset low cycle", lb_q[ilb], t0 + t);
                    end
                    ilb++;
                end
            end
        end
        check_val("buf1 read count", b1_q.size(), ib);
        check_val("shift_filter count", sf_q.size(), is);
        check_val("shift_line count", sl_q.size(), isl);
        check_val("mac count", mc_q.size(), imc);
        check_val("buf2 write count", wr_q.size(), iw);
        check_val("buf2 read count", rd_q.size(), ir);
        check_val("feedback_en count", fe_q.size(), ie);
        check_val("nl_en count", nl_q.size(), il);
        check_val("line_buffer_reset low count", lb_q.size(), ilb);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        check_val("buf1_rd_en", 32'(buf1_rd_en), 0);
        check_val("buf2_wr_en", 32'(buf2_wr_en), 0);
        check_val("buf2_rd_en", 32'(buf2_rd_en), 0);
        check_val("shift_filter_row", 32'(shift_filter_row), 0);
        check_val("shift_filter_lanes", 32'(shift_filter_lanes), 0);
        check_val("shift_line_rows", 32'(shift_line_rows), 0);
        check_val("shift_line_lanes", 32'(shift_line_lanes), 0);
        check_val("mac_rows", 32'(mac_rows), 0);
        check_val("mac_lanes", 32'(mac_lanes), 0);
        check_val("feedback_en", 32'(feedback_en), 0);
        check_val("nl_en", 32'(nl_en), 0);
        check_val("line_buffer_reset", 32'(line_buffer_reset), 1);
        check_val("busy", 32'(busy), 0);
        check_val("done", 32'(done), 0);
    endtask

    task automatic writeback_coverage();
        run_layer(8, 8, 6, 6, 3, 3);
        check_val("total writes", wr_q.size(), 2 * 2 * 16);  // FBe x CBe x output_size
        verify_layer(M_WR);
    endtask

    task automatic filter_push();
        run_layer(4, 8, 5, 5, 2, 2);
        verify_layer(M_PUSH);
    endtask

    task automatic partial_blocks();
        run_layer(pch, pfi, pdw, 5, pfw, 2);
        verify_layer(M_PUSH | M_WR);
    endtask

    task automatic feedback_gating();
        run_layer(12, 4, 6, 5, 3, 2);
        verify_layer(M_FB);
    endtask

    task automatic pass_timing();
        run_layer(4, 4, 7, 6, 3, 3);
        verify_layer(M_WR | M_TIME);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        cfg_channels = '0;
        cfg_filters = '0;
        cfg_data_wid = '0;
        cfg_data_hei = '0;
        cfg_filter_wid = '0;
        cfg_filter_hei = '0;
        // partial layer, never a multiple of N_PE
        pch = N_PE * (1 + $unsigned($random(seed)) % 2) + 1 + $unsigned($random(seed)) % 3;
        pfi = N_PE * (1 + $unsigned($random(seed)) % 2) + 1 + $unsigned($random(seed)) % 3;
        pdw = 5 + $unsigned($random(seed)) % 3;
        pfw = 2 + $unsigned($random(seed)) % 2;
        limit = budget(8, 8, 6, 6, 3, 3) + budget(4, 8, 5, 5, 2, 2)
              + budget(pch, pfi, pdw, 5, pfw, 2) + budget(12, 4, 6, 5, 3, 2)
              + budget(4, 4, 7, 6, 3, 3);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_state();
        writeback_coverage();
        filter_push();
        partial_blocks();
        feedback_gating();
        pass_timing();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/conv_geom_pkg.sv
hdl/conv_timing_pkg.sv
hdl/conv_geometry.sv
hdl/block_sequencer.sv
hdl/feedforward_sched.sv
hdl/feedback_sched.sv
hdl/conv_ctrl_top.sv
test/conv_ctrl_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := conv_ctrl_tb
FILELIST   := build.f
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
